//--- raster_mem.f
+incdir+design
+incdir+tb
design/raster_pkg.sv
design/scene_loader.sv
design/scene_store.sv
design/draw_walker.sv
design/raster_mem.sv
tb/raster_mem_tb.sv

//--- tb/raster_mem_tests.svh
`ifndef RASTER_MEM_TESTS_SVH
`define RASTER_MEM_TESTS_SVH

task automatic check_reset_values();
    if (status !== ST_OK) begin
        report_mismatch("status", status, ST_OK);
    end
    if (cmd_busy !== 1'b0) begin
        report_mismatch("cmd_busy", cmd_busy, 0);
    end
    if (draw_busy !== 1'b0) begin
        report_mismatch("draw_busy", draw_busy, 0);
    end
    if (draw_valid !== 1'b0) begin
        report_mismatch("draw_valid", draw_valid, 0);
    end
endtask

task automatic load_first_buffers();
    load_vertex_buffer(VBASE, 6, 0);
    if (status !== ST_OK) begin
        report_mismatch("status", status, ST_OK);
    end
    if (vert_id_out !== 4'd0) begin
        report_mismatch("vert_id_out", vert_id_out, 0);
    end
    load_triangle_buffer(TBASE, 4, 6);
    if (status !== ST_OK) begin
        report_mismatch("status", status, ST_OK);
    end
    if (tri_id_out !== 4'd0) begin
        report_mismatch("tri_id_out", tri_id_out, 0);
    end
endtask

task automatic draw_new_instance();
    live_xf         = random_transform();
    live_xf.vbuf_id = 4'd9;   // empty buffers, the loader binds buffers 0 instead
    live_xf.tbuf_id = 4'd9;
    strobe_opcode(OP_INST_NEW);
    send_transform(live_xf, 0);
    wait_cmd_idle();
    if (inst_id_out !== 4'd1) begin
        report_mismatch("inst_id_out", inst_id_out, 1);
    end
    draw_and_check(1, live_xf, VBASE, TBASE, 4);
endtask

task automatic update_and_redraw();
    live_xf = random_transform();
    strobe_opcode(OP_INST_UPD);
    send_transform(live_xf, 1);
    wait_cmd_idle();
    if (status !== ST_OK) begin
        report_mismatch("status", status, ST_OK);
    end
    draw_and_check(1, live_xf, VBASE, TBASE, 4);
endtask

task automatic provoke_error_codes();
    // overrun word would land on vertex 0 of the live buffer
    load_vertex_buffer(VBASE - 6, 6, 1);
    if (status !== ST_BAD_COUNT) begin
        report_mismatch("status", status, ST_BAD_COUNT);
    end
    if (vert_id_out !== 4'd1) begin
        report_mismatch("vert_id_out", vert_id_out, 1);
    end
    draw_and_check(1, live_xf, VBASE, TBASE, 4);
    strobe_opcode(4'd9);
    if (status !== ST_BAD_OP) begin
        report_mismatch("status", status, ST_BAD_OP);
    end
endtask

task automatic wipe_allocators();
    strobe_opcode(OP_WIPE);
    if (status !== ST_OK) begin
        report_mismatch("status", status, ST_OK);
    end
    load_vertex_buffer(200, 3, 0);
    if (vert_id_out !== 4'd0) begin
        report_mismatch("vert_id_out", vert_id_out, 0);
    end
    strobe_opcode(OP_INST_NEW);
    send_transform(random_transform(), 0);
    wait_cmd_idle();
    if (inst_id_out !== 4'd1) begin
        report_mismatch("inst_id_out", inst_id_out, 1);
    end
endtask

`endif

//--- tb/raster_mem_tb.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module raster_mem_tb;
    import raster_pkg::*;

    // six short tests fit well inside this limit
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int VBASE = 16;
    localparam int TBASE = 100;

    logic                     clk;
    logic                     rst;
    logic                     opcode_valid;
    opcode_e                  opcode;
    logic                     hdr_valid;
    logic [`RM_ADDR_W-1:0]    buf_base;
    logic [`RM_IDX_W-1:0]     buf_count;
    logic                     word_valid;
    load_word_u               load_word;
    logic                     inst_valid;
    transform_t               transform_in;
    logic [`RM_INST_ID_W-1:0] inst_id_in;
    status_e                  status;
    logic [`RM_BUF_ID_W-1:0]  vert_id_out;
    logic [`RM_BUF_ID_W-1:0]  tri_id_out;
    logic [`RM_INST_ID_W-1:0] inst_id_out;
    logic                     cmd_busy;
    logic                     rd_en;
    logic [`RM_INST_ID_W-1:0] rd_inst_id;
    logic                     draw_busy;
    logic [3*`RM_DATA_W-1:0]  cord_out;
    logic [3*`RM_DATA_W-1:0]  agl_out;
    logic [3*`RM_DATA_W-1:0]  scale_out;
    vertex_t                  vert_out;
    logic                     draw_valid;

    // reference model of what the scene memory should hold
    vertex_t    vtx_model [`RM_VERT_DEPTH];
    tri_t       tri_model [`RM_TRI_DEPTH];
    transform_t live_xf;      // transform of instance 1
    int         errors;
    int         cycle_cnt;

    raster_mem dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d errors so far", TIMEOUT_CYCLES, errors);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    function automatic vertex_t random_vertex();
        vertex_t v;
        v.x    = $urandom;
        v.y    = $urandom;
        v.z    = $urandom;
        v.attr = 12'($urandom);
        return v;
    endfunction

    function automatic transform_t random_transform();
        transform_t xf;
        xf = '0;
        for (int k = 0; k < 3; k++) begin
            xf.pos[k] = $urandom;
            xf.rot[k] = $urandom;
            xf.scl[k] = $urandom;
        end
        return xf;
    endfunction

    // every driver starts 2 ns after an edge and returns 2 ns after the next one
    task automatic strobe_opcode(input logic [3:0] op);
        opcode_valid = 1'b1;
        opcode       = opcode_e'(op);
        @(posedge clk);
        #2;
        opcode_valid = 1'b0;
    endtask

    task automatic send_header(input int base, input int count);
        hdr_valid = 1'b1;
        buf_base  = `RM_ADDR_W'(base);
        buf_count = `RM_IDX_W'(count);
        @(posedge clk);
        #2;
        hdr_valid = 1'b0;
    endtask

    task automatic send_word(input load_word_u w);
        word_valid = 1'b1;
        load_word  = w;
        @(posedge clk);
        #2;
        word_valid = 1'b0;
    endtask

    task automatic send_transform(input transform_t xf, input int id);
        inst_valid   = 1'b1;
        transform_in = xf;
        inst_id_in   = `RM_INST_ID_W'(id);
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic wait_cmd_idle();
        while (cmd_busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    // extra words follow the last one back to back and stay out of the model
    task automatic load_vertex_buffer(input int base, input int count, input int extra);
        load_word_u w;
        vertex_t    v;
        strobe_opcode(OP_VERT_BUF);
        send_header(base, count);
        for (int i = 0; i < count + extra; i++) begin
            v = random_vertex();
            if (i < count) begin
                vtx_model[base + i] = v;
            end
            w     = '0;
            w.vtx = v;
            send_word(w);
        end
        wait_cmd_idle();
    endtask

    task automatic load_triangle_buffer(input int base, input int count, input int nvert);
        load_word_u w;
        tri_t       t;
        strobe_opcode(OP_TRI_BUF);
        send_header(base, count);
        for (int i = 0; i < count; i++) begin
            for (int c = 0; c < 3; c++) begin
                t.idx[c] = `RM_IDX_W'((i + 2 * c) % nvert);   // touches every vertex
            end
            tri_model[base + i] = t;
            w         = '0;
            w.tw.face = t;
            send_word(w);
        end
        wait_cmd_idle();
    endtask

    task automatic draw_and_check(input int id, input transform_t exp_xf, input int vbase,
                                  input int tbase, input int ntri);
        vertex_t exp_q[$];
        tri_t    t;
        int      run;
        int      nv;
        for (int i = 0; i < ntri; i++) begin
            t = tri_model[tbase + i];
            for (int c = 0; c < 3; c++) begin
                exp_q.push_back(vtx_model[vbase + t.idx[c]]);
            end
        end
        rd_inst_id = `RM_INST_ID_W'(id);
        rd_en      = 1'b1;
        @(posedge clk);
        #2;
        rd_en = 1'b0;
        if (draw_busy !== 1'b1) begin
            $display("draw_busy did not rise the cycle after rd_en");
            errors++;
        end
        run = 0;
        nv  = 0;
        while (draw_busy === 1'b1) begin
            @(negedge clk);
            if (draw_valid === 1'b1) begin
                if (nv < exp_q.size() && vert_out !== exp_q[nv]) begin
                    report_mismatch("vert_out", vert_out, exp_q[nv]);
                end
                nv++;
                run++;
            end else if (run != 0) begin
                if (run != 3) begin
                    $display("draw_valid stayed high %0d cycles instead of 3", run);
                    errors++;
                end
                run = 0;
            end
        end
        if (nv != exp_q.size()) begin
            $display("draw gave %0d vertices, expected %0d", nv, exp_q.size());
            errors++;
        end
        if (cord_out !== exp_xf.pos) begin
            report_mismatch("cord_out", cord_out, exp_xf.pos);
        end
        if (agl_out !== exp_xf.rot) begin
            report_mismatch("agl_out", agl_out, exp_xf.rot);
        end
        if (scale_out !== exp_xf.scl) begin
            report_mismatch("scale_out", scale_out, exp_xf.scl);
        end
        @(posedge clk);
        #2;
    endtask

    `include "raster_mem_tests.svh"

    initial begin
        errors       = 0;
        void'($urandom(32'h0552_bff0));
        rst          = 1'b1;
        opcode_valid = 1'b0;
        opcode       = OP_WIPE;
        hdr_valid    = 1'b0;
        buf_base     = '0;
        buf_count    = '0;
        word_valid   = 1'b0;
        load_word    = '0;
        inst_valid   = 1'b0;
        transform_in = '0;
        inst_id_in   = '0;
        rd_en        = 1'b0;
        rd_inst_id   = '0;
        live_xf      = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_reset_values();
        load_first_buffers();
        draw_new_instance();
        update_and_redraw();
        provoke_error_codes();
        wipe_allocators();
        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- design/raster_mem.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module raster_mem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     opcode_valid,
    input  raster_pkg::opcode_e      opcode,
    input  logic                     hdr_valid,
    input  logic [`RM_ADDR_W-1:0]    buf_base,
    input  logic [`RM_IDX_W-1:0]     buf_count,
    input  logic                     word_valid,
    input  raster_pkg::load_word_u   load_word,
    input  logic                     inst_valid,
    input  raster_pkg::transform_t   transform_in,
    input  logic [`RM_INST_ID_W-1:0] inst_id_in,
    output raster_pkg::status_e      status,
    output logic [`RM_BUF_ID_W-1:0]  vert_id_out,
    output logic [`RM_BUF_ID_W-1:0]  tri_id_out,
    output logic [`RM_INST_ID_W-1:0] inst_id_out,
    output logic                     cmd_busy,
    input  logic                     rd_en,
    input  logic [`RM_INST_ID_W-1:0] rd_inst_id,
    output logic                     draw_busy,
    output logic [3*`RM_DATA_W-1:0]  cord_out,
    output logic [3*`RM_DATA_W-1:0]  agl_out,
    output logic [3*`RM_DATA_W-1:0]  scale_out,
    output raster_pkg::vertex_t      vert_out,
    output logic                     draw_valid
);
    import raster_pkg::*;

    // loader to store
    logic                     vtx_we;
    logic [`RM_ADDR_W-1:0]    vtx_waddr;
    vertex_t                  vtx_wdata;
    logic                     tri_we;
    logic [`RM_ADDR_W-1:0]    tri_waddr;
    tri_t                     tri_wdata;
    logic                     vdesc_we;
    logic                     tdesc_we;
    logic [`RM_BUF_ID_W-1:0]  desc_waddr;
    logic [`RM_ADDR_W-1:0]    desc_base;
    logic [`RM_IDX_W-1:0]     desc_count;
    logic                     inst_we;
    logic [`RM_INST_ID_W-1:0] inst_waddr;
    transform_t               inst_wdata;

    // walker to store and back
    logic [`RM_BUF_ID_W-1:0]  vdesc_raddr;
    logic [`RM_BUF_ID_W-1:0]  tdesc_raddr;
    logic [`RM_INST_ID_W-1:0] inst_raddr;
    logic [`RM_ADDR_W-1:0]    vtx_raddr;
    logic [`RM_ADDR_W-1:0]    tri_raddr;
    logic [`RM_ADDR_W-1:0]    vdesc_base;
    logic [`RM_IDX_W-1:0]     vdesc_count;
    logic [`RM_ADDR_W-1:0]    tdesc_base;
    logic [`RM_IDX_W-1:0]     tdesc_count;
    transform_t               inst_rdata;
    vertex_t                  vtx_rdata;
    tri_t                     tri_rdata;

    scene_loader u_loader (.*);

    scene_store u_store (.*);

    draw_walker u_walker (.*);

endmodule

//--- design/draw_walker.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module draw_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en,
    input  logic [`RM_INST_ID_W-1:0]   rd_inst_id,
    output logic [`RM_BUF_ID_W-1:0]    vdesc_raddr,
    output logic [`RM_BUF_ID_W-1:0]    tdesc_raddr,
    output logic [`RM_INST_ID_W-1:0]   inst_raddr,
    output logic [`RM_ADDR_W-1:0]      vtx_raddr,
    output logic [`RM_ADDR_W-1:0]      tri_raddr,
    input  logic [`RM_ADDR_W-1:0]      vdesc_base,
    input  logic [`RM_IDX_W-1:0]       vdesc_count,
    input  logic [`RM_ADDR_W-1:0]      tdesc_base,
    input  logic [`RM_IDX_W-1:0]       tdesc_count,
    input  raster_pkg::transform_t     inst_rdata,
    input  raster_pkg::vertex_t        vtx_rdata,
    input  raster_pkg::tri_t           tri_rdata,
    output logic                       draw_busy,
    output logic [3*`RM_DATA_W-1:0]    cord_out,
    output logic [3*`RM_DATA_W-1:0]    agl_out,
    output logic [3*`RM_DATA_W-1:0]    scale_out,
    output raster_pkg::vertex_t        vert_out,
    output logic                       draw_valid
);
    import raster_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_DESC, W_TRI, W_VERT} state_e;

    state_e                   state;
    logic [`RM_INST_ID_W-1:0] inst_q;
    logic [`RM_ADDR_W-1:0]    vbase;
    logic [`RM_ADDR_W-1:0]    tbase;
    logic [`RM_IDX_W-1:0]     tri_total;
    logic [`RM_IDX_W-1:0]     tri_cnt;
    tri_t                     cur_tri;
    logic [1:0]               vsel;        // corner within the triangle
    logic                     last_vert;
    logic                     last_tri;

    // descriptor lookup chains off the instance entry
    assign inst_raddr  = inst_q;
    assign vdesc_raddr = inst_rdata.vbuf_id;
    assign tdesc_raddr = inst_rdata.tbuf_id;
    assign tri_raddr   = tbase + tri_cnt;
    assign vtx_raddr   = vbase + cur_tri.idx[vsel];

    assign vert_out   = vtx_rdata;
    assign draw_valid = (state == W_VERT);
    assign draw_busy  = (state != W_IDLE);
    assign last_vert  = (vsel == 2'd2);
    assign last_tri   = (tri_cnt + 1'b1 == tri_total);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= W_IDLE;
            tri_cnt <= '0;
            vsel    <= '0;
        end else begin
            case (state)
                W_IDLE: if (rd_en) begin
                    state <= W_DESC;
                end
                W_DESC: begin
                    tri_cnt <= '0;
                    state   <= W_TRI;
                end
                W_TRI: begin
                    if (tri_cnt == tri_total) begin
                        state <= W_IDLE;        // empty buffer
                    end else begin
                        vsel  <= '0;
                        state <= W_VERT;
                    end
                end
                W_VERT: begin
                    vsel <= vsel + 1'b1;
                    if (last_vert) begin
                        tri_cnt <= tri_cnt + 1'b1;
                        state   <= last_tri ? W_IDLE : W_TRI;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_IDLE && rd_en) begin
            inst_q <= rd_inst_id;
        end
        if (state == W_DESC) begin
            cord_out  <= inst_rdata.pos;
            agl_out   <= inst_rdata.rot;
            scale_out <= inst_rdata.scl;
            vbase     <= vdesc_base;
            tbase     <= tdesc_base;
            tri_total <= (vdesc_count == '0) ? '0 : tdesc_count;  // nothing to draw without vertices
        end
        if (state == W_TRI) begin
            cur_tri <= tri_rdata;
        end
    end

endmodule

//--- design/scene_store.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module scene_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     vtx_we,
    input  logic [`RM_ADDR_W-1:0]    vtx_waddr,
    input  raster_pkg::vertex_t      vtx_wdata,
    input  logic                     tri_we,
    input  logic [`RM_ADDR_W-1:0]    tri_waddr,
    input  raster_pkg::tri_t         tri_wdata,
    input  logic                     vdesc_we,
    input  logic                     tdesc_we,
    input  logic [`RM_BUF_ID_W-1:0]  desc_waddr,
    input  logic [`RM_ADDR_W-1:0]    desc_base,
    input  logic [`RM_IDX_W-1:0]     desc_count,
    input  logic                     inst_we,
    input  logic [`RM_INST_ID_W-1:0] inst_waddr,
    input  raster_pkg::transform_t   inst_wdata,
    input  logic [`RM_BUF_ID_W-1:0]  vdesc_raddr,
    input  logic [`RM_BUF_ID_W-1:0]  tdesc_raddr,
    input  logic [`RM_INST_ID_W-1:0] inst_raddr,
    input  logic [`RM_ADDR_W-1:0]    vtx_raddr,
    input  logic [`RM_ADDR_W-1:0]    tri_raddr,
    output logic [`RM_ADDR_W-1:0]    vdesc_base,
    output logic [`RM_IDX_W-1:0]     vdesc_count,
    output logic [`RM_ADDR_W-1:0]    tdesc_base,
    output logic [`RM_IDX_W-1:0]     tdesc_count,
    output raster_pkg::transform_t   inst_rdata,
    output raster_pkg::vertex_t      vtx_rdata,
    output raster_pkg::tri_t         tri_rdata
);
    import raster_pkg::*;

    vertex_t    vtx_ram  [`RM_VERT_DEPTH];
    tri_t       tri_ram  [`RM_TRI_DEPTH];
    transform_t inst_ram [`RM_INST_CNT];

    // descriptor entry is {base, count}
    logic [`RM_ADDR_W+`RM_IDX_W-1:0] vdesc_tab [`RM_BUF_CNT];
    logic [`RM_ADDR_W+`RM_IDX_W-1:0] tdesc_tab [`RM_BUF_CNT];

    always_ff @(posedge clk) begin
        if (vtx_we) begin
            vtx_ram[vtx_waddr] <= vtx_wdata;
        end
        if (tri_we) begin
            tri_ram[tri_waddr] <= tri_wdata;
        end
        if (inst_we) begin
            inst_ram[inst_waddr] <= inst_wdata;
        end
    end

    // unused buffers read back as empty
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RM_BUF_CNT; i++) begin
                vdesc_tab[i] <= '0;
                tdesc_tab[i] <= '0;
            end
        end else begin
            if (vdesc_we) begin
                vdesc_tab[desc_waddr] <= {desc_base, desc_count};
            end
            if (tdesc_we) begin
                tdesc_tab[desc_waddr] <= {desc_base, desc_count};
            end
        end
    end

    assign {vdesc_base, vdesc_count} = vdesc_tab[vdesc_raddr];
    assign {tdesc_base, tdesc_count} = tdesc_tab[tdesc_raddr];
    assign inst_rdata = inst_ram[inst_raddr];
    assign vtx_rdata  = vtx_ram[vtx_raddr];
    assign tri_rdata  = tri_ram[tri_raddr];

endmodule

//--- design/scene_loader.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module scene_loader (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     opcode_valid,
    input  raster_pkg::opcode_e      opcode,
    input  logic                     hdr_valid,
    input  logic [`RM_ADDR_W-1:0]    buf_base,
    input  logic [`RM_IDX_W-1:0]     buf_count,
    input  logic                     word_valid,
    input  raster_pkg::load_word_u   load_word,
    input  logic                     inst_valid,
    input  raster_pkg::transform_t   transform_in,
    input  logic [`RM_INST_ID_W-1:0] inst_id_in,
    output raster_pkg::status_e      status,
    output logic [`RM_BUF_ID_W-1:0]  vert_id_out,
    output logic [`RM_BUF_ID_W-1:0]  tri_id_out,
    output logic [`RM_INST_ID_W-1:0] inst_id_out,
    output logic                     cmd_busy,
    output logic                     vtx_we,
    output logic [`RM_ADDR_W-1:0]    vtx_waddr,
    output raster_pkg::vertex_t      vtx_wdata,
    output logic                     tri_we,
    output logic [`RM_ADDR_W-1:0]    tri_waddr,
    output raster_pkg::tri_t         tri_wdata,
    output logic                     vdesc_we,
    output logic                     tdesc_we,
    output logic [`RM_BUF_ID_W-1:0]  desc_waddr,
    output logic [`RM_ADDR_W-1:0]    desc_base,
    output logic [`RM_IDX_W-1:0]     desc_count,
    output logic                     inst_we,
    output logic [`RM_INST_ID_W-1:0] inst_waddr,
    output raster_pkg::transform_t   inst_wdata
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_VERT_HDR, S_VERT_DATA, S_TRI_HDR, S_TRI_DATA, S_INST_NEW, S_INST_UPD
    } state_e;

    state_e                   state;
    logic [`RM_BUF_ID_W-1:0]  next_vert_id;
    logic [`RM_BUF_ID_W-1:0]  next_tri_id;
    logic [`RM_INST_ID_W-1:0] next_inst_id;
    logic [`RM_ADDR_W-1:0]    cur_base;
    logic [`RM_IDX_W-1:0]     cur_count;
    logic [`RM_IDX_W-1:0]     item_cnt;     // words written so far
    logic                     in_data;
    logic                     buf_full;
    logic                     hdr_take;
    logic                     word_take;

    assign in_data   = (state == S_VERT_DATA) || (state == S_TRI_DATA);
    assign buf_full  = (item_cnt == cur_count);
    assign hdr_take  = hdr_valid && ((state == S_VERT_HDR) || (state == S_TRI_HDR));
    assign word_take = word_valid && in_data && !buf_full;
    assign cmd_busy  = (state != S_IDLE);

    // load word goes to whichever RAM the state selects
    assign vtx_we    = word_take && (state == S_VERT_DATA);
    assign tri_we    = word_take && (state == S_TRI_DATA);
    assign vtx_waddr = cur_base + item_cnt;
    assign tri_waddr = cur_base + item_cnt;
    assign vtx_wdata = load_word.vtx;
    assign tri_wdata = load_word.tw.face;

    assign vdesc_we   = hdr_take && (state == S_VERT_HDR);
    assign tdesc_we   = hdr_take && (state == S_TRI_HDR);
    assign desc_waddr = (state == S_TRI_HDR) ? next_tri_id : next_vert_id;
    assign desc_base  = buf_base;
    assign desc_count = buf_count;

    assign inst_we    = inst_valid && ((state == S_INST_NEW) || (state == S_INST_UPD));
    assign inst_waddr = (state == S_INST_NEW) ? next_inst_id : inst_id_in;

    always_comb begin
        inst_wdata = transform_in;
        if (state == S_INST_NEW) begin
            // new instance binds the most recently created buffers
            inst_wdata.vbuf_id = vert_id_out;
            inst_wdata.tbuf_id = tri_id_out;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= S_IDLE;
            status       <= ST_OK;
            next_vert_id <= '0;
            next_tri_id  <= '0;
            next_inst_id <= `RM_INST_ID_W'(1);   // 0 is the camera
            vert_id_out  <= '0;
            tri_id_out   <= '0;
            inst_id_out  <= '0;
            item_cnt     <= '0;
        end else begin
            case (state)
                S_IDLE: if (opcode_valid) begin
                    case (opcode)
                        OP_WIPE: begin
                            next_vert_id <= '0;
                            next_tri_id  <= '0;
                            next_inst_id <= `RM_INST_ID_W'(1);
                            status       <= ST_OK;
                        end
                        OP_VERT_BUF: state  <= S_VERT_HDR;
                        OP_TRI_BUF:  state  <= S_TRI_HDR;
                        OP_INST_NEW: state  <= S_INST_NEW;
                        OP_INST_UPD: state  <= S_INST_UPD;
                        default:     status <= ST_BAD_OP;
                    endcase
                end
                S_VERT_HDR, S_TRI_HDR: if (hdr_valid) begin
                    item_cnt <= '0;
                    if (state == S_VERT_HDR) begin
                        vert_id_out  <= next_vert_id;
                        next_vert_id <= next_vert_id + 1'b1;
                        state        <= S_VERT_DATA;
                    end else begin
                        tri_id_out  <= next_tri_id;
                        next_tri_id <= next_tri_id + 1'b1;
                        state       <= S_TRI_DATA;
                    end
                end
                S_VERT_DATA, S_TRI_DATA: begin
                    if (buf_full) begin
                        status <= word_valid ? ST_BAD_COUNT : ST_OK;  // word past the end
                        state  <= S_IDLE;
                    end else if (word_valid) begin
                        item_cnt <= item_cnt + 1'b1;
                    end
                end
                S_INST_NEW: if (inst_valid) begin
                    inst_id_out  <= next_inst_id;
                    next_inst_id <= next_inst_id + 1'b1;
                    status       <= ST_OK;
                    state        <= S_IDLE;
                end
                S_INST_UPD: if (inst_valid) begin
                    status <= ST_OK;
                    state  <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
            if (opcode_valid && state != S_IDLE) begin
                status <= ST_BAD_OP;   // opcode while busy is dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            cur_base  <= buf_base;
            cur_count <= buf_count;
        end
    end

endmodule

//--- design/raster_pkg.sv
`include "raster_config.svh"

package raster_pkg;

    typedef enum logic [3:0] {
        OP_WIPE     = 4'd0,
        OP_VERT_BUF = 4'd1,
        OP_TRI_BUF  = 4'd2,
        OP_INST_NEW = 4'd3,
        OP_INST_UPD = 4'd4
    } opcode_e;

    typedef enum logic [3:0] {
        ST_OK        = 4'd0,
        ST_BAD_COUNT = 4'd2,
        ST_BAD_OP    = 4'd3
    } status_e;

    // 3 x 32 bit coordinates, 3 attribute nibbles
    typedef struct packed {
        logic [`RM_DATA_W-1:0] x;
        logic [`RM_DATA_W-1:0] y;
        logic [`RM_DATA_W-1:0] z;
        logic [2:0][3:0]       attr;
    } vertex_t;

    typedef struct packed {
        logic [2:0][`RM_IDX_W-1:0] idx;    // idx[0] in the low bits
    } tri_t;

    typedef struct packed {
        logic [$bits(vertex_t)-$bits(tri_t)-1:0] pad;
        tri_t                                    face;
    } tri_word_t;

    // one load word, vertex or triangle depending on the command
    typedef union packed {
        vertex_t   vtx;
        tri_word_t tw;
    } load_word_u;

    typedef struct packed {
        logic [2:0][`RM_DATA_W-1:0] pos;
        logic [2:0][`RM_DATA_W-1:0] rot;
        logic [2:0][`RM_DATA_W-1:0] scl;
        logic [`RM_BUF_ID_W-1:0]    vbuf_id;
        logic [`RM_BUF_ID_W-1:0]    tbuf_id;
    } transform_t;

endpackage

//--- design/raster_config.svh
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// memory depths, kept small for simulation
`define RM_VERT_DEPTH 1024
`define RM_TRI_DEPTH  1024
`define RM_BUF_CNT    16    // vertex and triangle buffers each
`define RM_INST_CNT   16    // entry 0 is the camera

`define RM_IDX_W      8     // vertex index and buffer count
`define RM_DATA_W     32    // one float
`define RM_ADDR_W     10    // covers both RAM depths
`define RM_BUF_ID_W   4
`define RM_INST_ID_W  4

`endif
